//--- all.f
+incdir+.
dmaPkg.sv
dmaRegisters.sv
dmaPriority.sv
dmaTimingControl.sv
dmaController.sv
dmaTb.sv

//--- dmaController.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dmaController import dmaPkg::*;
(
        input logic dma_if,
        input logic rstN,
        input dmaCpuBus_t cpu,
        output logic [7:0] dataOut,
        input logic [`DMA_CHANNELS-1:0] dreq,
        input logic hlda,
        output logic hrq,
        output dmaBusCycle_t bus
);

        logic [`DMA_CHANNELS-1:0] maskBits;
        logic [`DMA_CHANNELS-1:0] softReq;
        dmaCommand_t command;
        dmaMode_t chanMode;
        logic [`DMA_ADDR_W-1:0] chanAddr;
        dmaGrant_t grant;
        logic advance;
        logic [1:0] advanceChan;
        logic terminalCount;

        dmaRegisters registers (.dma_if, .rstN, .cpu, .dataOut, .dreq, .advance,
                .advanceChan, .terminalCount, .maskBits, .softReq, .command,
                .chanMode, .chanAddr);

        // Arbitration over unmasked DREQ and software requests
        dmaPriority priorityArb (.dma_if, .rstN, .dreq, .softReq, .maskBits,
                .command, .advance, .grant);

        dmaTimingControl timing (.dma_if, .rstN, .grant, .hlda, .chanMode,
                .chanAddr, .terminalCount, .hrq, .bus, .advance, .advanceChan);

endmodule

//--- dmaPkg.sv
`include "dma_params.svh"

package dmaPkg;

        // Code 2'b11 behaves as verify
        typedef enum logic [1:0] {
                verify = 2'b00,
                toMemory = 2'b01,
                fromMemory = 2'b10
        } dmaXferType_t;

        typedef enum logic [1:0] {idle, request, address, strobe} dmaTimingState_t;

        // Matches bits 5:2 of the mode byte
        typedef struct packed {
                logic decrement;
                logic autoInit;
                dmaXferType_t xferType;
        } dmaMode_t;

        typedef struct packed {
                logic rotating;
                logic ctrlDisable;
        } dmaCommand_t;

        typedef struct packed {
                logic cs;
                logic rd;
                logic wr;
                logic [3:0] offset;
                logic [7:0] dataIn;
        } dmaCpuBus_t;

        typedef struct packed {
                logic [`DMA_ADDR_W-1:0] addr;
                logic [`DMA_CHANNELS-1:0] dack;
                logic memRead;
                logic memWrite;
                logic ioRead;
                logic ioWrite;
                logic eop;
        } dmaBusCycle_t;

        typedef struct packed {
                logic valid;
                logic [1:0] chan;
        } dmaGrant_t;

endpackage

//--- dmaPriority.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dmaPriority import dmaPkg::*;
(
        input logic dma_if,
        input logic rstN,
        input logic [`DMA_CHANNELS-1:0] dreq,
        input logic [`DMA_CHANNELS-1:0] softReq,
        input logic [`DMA_CHANNELS-1:0] maskBits,
        input dmaCommand_t command,
        input logic advance,
        output dmaGrant_t grant
);

        logic [`DMA_CHANNELS-1:0] active;
        logic [1:0] lastServed;
        logic [1:0] servedChan;
        logic [1:0] startChan;
        logic [1:0] probe;
        logic inFlight;

        // Software requests bypass the mask
        assign active = (dreq & ~maskBits) | softReq;
        assign startChan = command.rotating ? lastServed + 2'd1 : 2'd0;

        // Scan from lowest priority so the highest match wins
        always_comb
        begin
                grant = '0;
                probe = '0;
                for (int i = `DMA_CHANNELS - 1; i >= 0; i--)
                begin
                        probe = startChan + 2'(i);
                        if (active[probe])
                        begin
                                grant.valid = 1'b1;
                                grant.chan = probe;
                        end
                end
                if (command.ctrlDisable)
                        grant = '0;
        end

        // Track the channel taken by the timing FSM until its advance
        always_ff @(posedge dma_if)
        begin
                if (!rstN)
                begin
                        inFlight <= 1'b0;
                        lastServed <= 2'd3;
                end
                else if (advance)
                begin
                        inFlight <= 1'b0;
                        lastServed <= servedChan;
                end
                else if (grant.valid)
                        inFlight <= 1'b1;
        end

        always_ff @(posedge dma_if)
        begin
                if (grant.valid && !inFlight)
                        servedChan <= grant.chan;
        end

endmodule

//--- dmaRegisters.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dmaRegisters import dmaPkg::*;
(
        input logic dma_if,
        input logic rstN,
        input dmaCpuBus_t cpu,
        output logic [7:0] dataOut,
        input logic [`DMA_CHANNELS-1:0] dreq,
        input logic advance,
        input logic [1:0] advanceChan,
        output logic terminalCount,
        output logic [`DMA_CHANNELS-1:0] maskBits,
        output logic [`DMA_CHANNELS-1:0] softReq,
        output dmaCommand_t command,
        output dmaMode_t chanMode,
        output logic [`DMA_ADDR_W-1:0] chanAddr
);

        logic [`DMA_ADDR_W-1:0] baseAddr [`DMA_CHANNELS];
        logic [`DMA_ADDR_W-1:0] baseCount [`DMA_CHANNELS];
        logic [`DMA_ADDR_W-1:0] curAddr [`DMA_CHANNELS];
        logic [`DMA_ADDR_W-1:0] curCount [`DMA_CHANNELS];
        dmaMode_t modeReg [`DMA_CHANNELS];
        logic [`DMA_CHANNELS-1:0] tcStatus;
        logic flipFlop;
        logic wrStrobe;
        logic rdStrobe;
        logic chanWrite;
        logic chanAccess;
        logic masterClear;
        logic [1:0] chanSel;
        logic [`DMA_ADDR_W-1:0] readWord;

        // Replace one byte of a 16-bit register with the pointer picking the high byte
        function automatic logic [`DMA_ADDR_W-1:0] loadByte(
                input logic [`DMA_ADDR_W-1:0] word,
                input logic [7:0] data,
                input logic highByte
        );
                logic [`DMA_ADDR_W-1:0] result;
                result = word;
                if (highByte)
                        result[15:8] = data;
                else
                        result[7:0] = data;
                return result;
        endfunction

        assign wrStrobe = cpu.cs && cpu.wr;
        assign rdStrobe = cpu.cs && cpu.rd;
        assign chanSel = cpu.offset[2:1];
        assign chanWrite = wrStrobe && !cpu.offset[3];
        assign chanAccess = (wrStrobe || rdStrobe) && !cpu.offset[3];
        assign masterClear = wrStrobe && (cpu.offset == `DMA_OFF_MASTERCLEAR);

        // Address and count registers plus byte pointer
        always_ff @(posedge dma_if)
        begin
                if (!rstN || masterClear)
                begin
                        for (int i = 0; i < `DMA_CHANNELS; i++)
                        begin
                                baseAddr[i] <= '0;
                                baseCount[i] <= '0;
                                curAddr[i] <= '0;
                                curCount[i] <= '0;
                        end
                        flipFlop <= 1'b0;
                end
                else
                begin
                        if (chanAccess)
                                flipFlop <= !flipFlop;
                        else if (wrStrobe && cpu.offset == `DMA_OFF_CLEARFF)
                                flipFlop <= 1'b0;

                        // CPU writes land in base and current together
                        if (chanWrite && cpu.offset[0])
                        begin
                                baseCount[chanSel] <= loadByte(baseCount[chanSel],
                                                               cpu.dataIn, flipFlop);
                                curCount[chanSel] <= loadByte(curCount[chanSel],
                                                              cpu.dataIn, flipFlop);
                        end
                        else if (chanWrite)
                        begin
                                baseAddr[chanSel] <= loadByte(baseAddr[chanSel],
                                                              cpu.dataIn, flipFlop);
                                curAddr[chanSel] <= loadByte(curAddr[chanSel],
                                                             cpu.dataIn, flipFlop);
                        end

                        if (advance && terminalCount && chanMode.autoInit)
                        begin
                                curAddr[advanceChan] <= baseAddr[advanceChan];
                                curCount[advanceChan] <= baseCount[advanceChan];
                        end
                        else if (advance && !terminalCount)
                        begin
                                curAddr[advanceChan] <= chanMode.decrement ? chanAddr - 1'b1
                                                                           : chanAddr + 1'b1;
                                curCount[advanceChan] <= curCount[advanceChan] - 1'b1;
                        end
                end
        end

        // Mode, command, request, mask and status
        always_ff @(posedge dma_if)
        begin
                if (!rstN || masterClear)
                begin
                        for (int i = 0; i < `DMA_CHANNELS; i++)
                                modeReg[i] <= '0;
                        command <= '0;
                        softReq <= '0;
                        maskBits <= '1;
                        tcStatus <= '0;
                end
                else
                begin
                        if (wrStrobe)
                        begin
                                case (cpu.offset)
                                `DMA_OFF_STATUS:
                                begin
                                        command.rotating <= cpu.dataIn[4];
                                        command.ctrlDisable <= cpu.dataIn[2];
                                end
                                `DMA_OFF_REQUEST: softReq[cpu.dataIn[1:0]] <= cpu.dataIn[2];
                                `DMA_OFF_SINGLEMASK: maskBits[cpu.dataIn[1:0]] <= cpu.dataIn[2];
                                `DMA_OFF_MODE: modeReg[cpu.dataIn[1:0]] <= dmaMode_t'(cpu.dataIn[5:2]);
                                `DMA_OFF_CLEARMASK: maskBits <= '0;
                                `DMA_OFF_ALLMASK: maskBits <= cpu.dataIn[3:0];
                                default: ;
                                endcase
                        end

                        // Status read clears TC bits
                        if (rdStrobe && cpu.offset == `DMA_OFF_STATUS)
                                tcStatus <= '0;

                        if (advance && terminalCount)
                        begin
                                tcStatus[advanceChan] <= 1'b1;
                                softReq[advanceChan] <= 1'b0;
                                if (!chanMode.autoInit)
                                        maskBits[advanceChan] <= 1'b1;
                        end
                end
        end

        assign readWord = cpu.offset[0] ? curCount[chanSel] : curAddr[chanSel];

        // Readback mux drives zero outside a read
        always_comb
        begin
                dataOut = '0;
                if (rdStrobe && !cpu.offset[3])
                        dataOut = flipFlop ? readWord[15:8] : readWord[7:0];
                else if (rdStrobe && cpu.offset == `DMA_OFF_STATUS)
                        dataOut = {dreq, tcStatus};
        end

        assign chanMode = modeReg[advanceChan];
        assign chanAddr = curAddr[advanceChan];
        assign terminalCount = (curCount[advanceChan] == '0);

endmodule

//--- dmaTb.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dmaTb import dmaPkg::*;
();

        // Transfers of up to 10 cycles and CPU accesses of 2 cycles plus a reset margin
        localparam int xferBudget = 200;
        localparam int accessBudget = 800;
        localparam int cycleLimit = xferBudget * 10 + accessBudget * 2 + 400;

        logic dma_if;
        logic rstN;
        dmaCpuBus_t cpu;
        logic [7:0] dataOut;
        logic [`DMA_CHANNELS-1:0] dreq;
        logic hlda;
        logic hrq;
        dmaBusCycle_t bus;

        logic [15:0] lfsr;
        int cycleCount;

        // Reference model of the register file and arbiter
        logic [`DMA_ADDR_W-1:0] refBaseAddr [`DMA_CHANNELS];
        logic [`DMA_ADDR_W-1:0] refBaseCount [`DMA_CHANNELS];
        logic [`DMA_ADDR_W-1:0] refAddr [`DMA_CHANNELS];
        logic [`DMA_ADDR_W-1:0] refCount [`DMA_CHANNELS];
        dmaMode_t refMode [`DMA_CHANNELS];
        logic [`DMA_CHANNELS-1:0] refMask;
        logic [`DMA_CHANNELS-1:0] refSoft;
        logic [`DMA_CHANNELS-1:0] refTc;
        logic refFf;
        logic refRotating;
        logic refDisable;
        logic [1:0] refLast;

        dmaController UUT (.dma_if, .rstN, .cpu, .dataOut, .dreq, .hlda, .hrq, .bus);

        always #10 dma_if = ~dma_if;

        always @(posedge dma_if)
        begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= cycleLimit)
                begin
                        $display("Timeout: the run went past %0d clock cycles", cycleLimit);
                        reportFailure();
                end
        end

        task automatic reportFailure();
                $display("Test failures found");
                $fatal(1, "Simulation stopped at the first error");
        endtask

        // Galois LFSR stepped once per bit taken
        function automatic logic [15:0] randBits(input int n);
                logic [15:0] value;
                logic outBit;
                value = '0;
                for (int i = 0; i < n; i++)
                begin
                        outBit = lfsr[0];
                        lfsr = lfsr >> 1;
                        if (outBit)
                                lfsr = lfsr ^ 16'hB400;
                        value = {value[14:0], outBit};
                end
                return value;
        endfunction

        task automatic checkByte(input string name, input logic [7:0] got,
                        input logic [7:0] expected);
                if (got !== expected)
                begin
                        $display("[ERROR] %s got %h expected %h", name, got, expected);
                        reportFailure();
                end
        endtask

        task automatic checkCycle(input dmaBusCycle_t got, input dmaBusCycle_t expected);
                if (got !== expected)
                begin
                        $display("[ERROR] bus got %h expected %h", got, expected);
                        reportFailure();
                end
        endtask

        task automatic checkHrq(input logic got, input logic expected);
                if (got !== expected)
                begin
                        $display("[ERROR] hrq got %h expected %h", got, expected);
                        reportFailure();
                end
        endtask

        function automatic void clearModel();
                for (int i = 0; i < `DMA_CHANNELS; i++)
                begin
                        refBaseAddr[i] = '0;
                        refBaseCount[i] = '0;
                        refAddr[i] = '0;
                        refCount[i] = '0;
                        refMode[i] = '0;
                end
                refMask = '1;
                refSoft = '0;
                refTc = '0;
                refFf = 1'b0;
                refRotating = 1'b0;
                refDisable = 1'b0;
        endfunction

        function automatic void applyWrite(input logic [3:0] offset, input logic [7:0] data);
                logic [1:0] ch;
                ch = offset[2:1];
                if (offset < 4'd8)
                begin
                        // Base and current take the same byte
                        if (offset[0] && refFf)
                        begin
                                refBaseCount[ch][15:8] = data;
                                refCount[ch][15:8] = data;
                        end
                        else if (offset[0])
                        begin
                                refBaseCount[ch][7:0] = data;
                                refCount[ch][7:0] = data;
                        end
                        else if (refFf)
                        begin
                                refBaseAddr[ch][15:8] = data;
                                refAddr[ch][15:8] = data;
                        end
                        else
                        begin
                                refBaseAddr[ch][7:0] = data;
                                refAddr[ch][7:0] = data;
                        end
                        refFf = !refFf;
                end
                else
                begin
                        case (offset)
                        `DMA_OFF_STATUS:
                        begin
                                refRotating = data[4];
                                refDisable = data[2];
                        end
                        `DMA_OFF_REQUEST: refSoft[data[1:0]] = data[2];
                        `DMA_OFF_SINGLEMASK: refMask[data[1:0]] = data[2];
                        `DMA_OFF_MODE: refMode[data[1:0]] = dmaMode_t'(data[5:2]);
                        `DMA_OFF_CLEARFF: refFf = 1'b0;
                        `DMA_OFF_MASTERCLEAR: clearModel();
                        `DMA_OFF_CLEARMASK: refMask = '0;
                        `DMA_OFF_ALLMASK: refMask = data[3:0];
                        default: ;
                        endcase
                end
        endfunction

        function automatic logic [7:0] expectedRead(input logic [3:0] offset);
                logic [7:0] value;
                logic [15:0] word;
                value = '0;
                if (offset < 4'd8)
                begin
                        word = offset[0] ? refCount[offset[2:1]] : refAddr[offset[2:1]];
                        value = refFf ? word[15:8] : word[7:0];
                        refFf = !refFf;
                end
                else if (offset == `DMA_OFF_STATUS)
                begin
                        value = {dreq, refTc};
                        refTc = '0;
                end
                return value;
        endfunction

        // Channel the arbiter should pick from idle or -1 for none
        function automatic int predictGrant();
                logic [3:0] active;
                logic [1:0] first;
                logic [1:0] probe;
                active = (dreq & ~refMask) | refSoft;
                first = refRotating ? refLast + 2'd1 : 2'd0;
                if (refDisable)
                        return -1;
                for (int i = 0; i < `DMA_CHANNELS; i++)
                begin
                        probe = first + 2'(i);
                        if (active[probe])
                                return int'(probe);
                end
                return -1;
        endfunction

        task automatic cpuWrite(input logic [3:0] offset, input logic [7:0] data);
                @(negedge dma_if);
                cpu = '0;
                cpu.cs = 1'b1;
                cpu.wr = 1'b1;
                cpu.offset = offset;
                cpu.dataIn = data;
                @(negedge dma_if);
                cpu = '0;
                applyWrite(offset, data);
        endtask

        task automatic cpuRead(input logic [3:0] offset);
                logic [7:0] expected;
                @(negedge dma_if);
                cpu = '0;
                cpu.cs = 1'b1;
                cpu.rd = 1'b1;
                cpu.offset = offset;
                expected = expectedRead(offset);
                #5;
                checkByte("dataOut", dataOut, expected);
                @(negedge dma_if);
                cpu = '0;
        endtask

        task automatic programChannel(input logic [1:0] ch, input logic [15:0] addr,
                        input logic [15:0] count);
                cpuWrite(`DMA_OFF_CLEARFF, 8'h00);
                cpuWrite({1'b0, ch, 1'b0}, addr[7:0]);
                cpuWrite({1'b0, ch, 1'b0}, addr[15:8]);
                cpuWrite({1'b0, ch, 1'b1}, count[7:0]);
                cpuWrite({1'b0, ch, 1'b1}, count[15:8]);
        endtask

        task automatic readChannel(input logic [1:0] ch);
                cpuWrite(`DMA_OFF_CLEARFF, 8'h00);
                cpuRead({1'b0, ch, 1'b0});
                cpuRead({1'b0, ch, 1'b0});
                cpuRead({1'b0, ch, 1'b1});
                cpuRead({1'b0, ch, 1'b1});
        endtask

        task automatic expectIdle(input int cycles);
                repeat (cycles)
                begin
                        @(negedge dma_if);
                        checkHrq(hrq, 1'b0);
                end
        endtask

        // One single transfer of the predicted channel with hlda after a random delay
        task automatic runTransfer(input logic dropReq);
                int ch;
                int delay;
                dmaBusCycle_t expected;
                ch = predictGrant();
                expected = '0;
                while (!hrq)
                        @(negedge dma_if);
                delay = int'(randBits(2));
                repeat (delay)
                begin
                        checkCycle(bus, expected);
                        @(negedge dma_if);
                end
                hlda = 1'b1;
                expected.addr = refAddr[ch];
                expected.dack = 4'b0001 << ch;
                @(negedge dma_if);
                #5;
                checkCycle(bus, expected);
                // Strobe cycle two clocks after hlda
                @(negedge dma_if);
                if (dropReq)
                        dreq = '0;
                case (refMode[ch].xferType)
                toMemory:
                begin
                        expected.ioRead = 1'b1;
                        expected.memWrite = 1'b1;
                end
                fromMemory:
                begin
                        expected.memRead = 1'b1;
                        expected.ioWrite = 1'b1;
                end
                default: ;
                endcase
                expected.eop = (refCount[ch] == '0);
                #5;
                checkCycle(bus, expected);
                if (refCount[ch] == '0)
                begin
                        refTc[ch] = 1'b1;
                        refSoft[ch] = 1'b0;
                        if (refMode[ch].autoInit)
                        begin
                                refAddr[ch] = refBaseAddr[ch];
                                refCount[ch] = refBaseCount[ch];
                        end
                        else
                                refMask[ch] = 1'b1;
                end
                else
                begin
                        refAddr[ch] = refMode[ch].decrement ? refAddr[ch] - 16'd1
                                                            : refAddr[ch] + 16'd1;
                        refCount[ch] = refCount[ch] - 16'd1;
                end
                refLast = 2'(ch);
                @(negedge dma_if);
                hlda = 1'b0;
                checkHrq(hrq, 1'b0);
        endtask

        task automatic serveTransfers(input int count);
                for (int t = 0; t < count; t++)
                begin
                        if (predictGrant() < 0)
                                break;
                        runTransfer(t == count - 1);
                end
                if (predictGrant() < 0)
                        expectIdle(3);
                dreq = '0;
        endtask

        initial
        begin
                logic [1:0] ch;
                logic [1:0] op;
                logic [3:0] modeBits;
                logic [15:0] count;
                dma_if = 1'b0;
                rstN = 1'b0;
                cpu = '0;
                dreq = '0;
                hlda = 1'b0;
                lfsr = 16'd71;
                cycleCount = 0;
                clearModel();
                // Channel 0 comes first in rotating mode after reset
                refLast = 2'd3;
                repeat (4) @(posedge dma_if);
                @(negedge dma_if);
                rstN = 1'b1;
                checkCycle(bus, '0);
                // All channels come out of reset masked
                dreq = '1;
                expectIdle(2);
                dreq = '0;

                // Byte-wise programming and readback
                for (int c = 0; c < `DMA_CHANNELS; c++)
                        programChannel(2'(c), randBits(16), randBits(16));
                for (int c = 0; c < `DMA_CHANNELS; c++)
                        readChannel(2'(c));
                for (int i = 0; i < 48; i++)
                begin
                        op = 2'(randBits(2));
                        if (op == 2'd3)
                                cpuWrite(`DMA_OFF_CLEARFF, 8'h00);
                        else if (op == 2'd2)
                                cpuRead(4'(randBits(3)));
                        else
                                cpuWrite(4'(randBits(3)), 8'(randBits(8)));
                end
                for (int c = 0; c < `DMA_CHANNELS; c++)
                        readChannel(2'(c));

                // Single transfers up to terminal count and one more request
                for (int r = 0; r < 8; r++)
                begin
                        ch = 2'(randBits(2));
                        count = randBits(2);
                        modeBits = 4'(randBits(4));
                        programChannel(ch, randBits(16), count);
                        cpuWrite(`DMA_OFF_MODE, {2'b00, modeBits, ch});
                        cpuWrite(`DMA_OFF_SINGLEMASK, {6'd0, ch});
                        dreq[ch] = 1'b1;
                        serveTransfers(int'(count) + 1);
                        dreq[ch] = 1'b1;
                        serveTransfers(1);
                        cpuRead(`DMA_OFF_STATUS);
                        cpuRead(`DMA_OFF_STATUS);
                        cpuWrite(`DMA_OFF_SINGLEMASK, {5'd0, 1'b1, ch});
                        readChannel(ch);
                end

                // Fixed then rotating priority with auto-init on every channel
                for (int c = 0; c < `DMA_CHANNELS; c++)
                begin
                        modeBits = 4'(randBits(4)) | 4'b0100;
                        programChannel(2'(c), randBits(16), randBits(3));
                        cpuWrite(`DMA_OFF_MODE, {2'b00, modeBits, 2'(c)});
                end
                cpuWrite(`DMA_OFF_CLEARMASK, 8'h00);
                dreq = 4'(randBits(4)) | 4'b1001;
                serveTransfers(6);
                cpuWrite(`DMA_OFF_STATUS, 8'h10);
                dreq = 4'(randBits(4)) | 4'b0110;
                serveTransfers(10);
                cpuRead(`DMA_OFF_STATUS);
                cpuWrite(`DMA_OFF_STATUS, 8'h14);
                dreq = 4'hF;
                serveTransfers(2);
                cpuWrite(`DMA_OFF_STATUS, 8'h00);
                dreq = 4'hF;
                serveTransfers(3);

                // Masks decide which held DREQs are served
                cpuWrite(`DMA_OFF_ALLMASK, 8'h0F);
                dreq = 4'hF;
                serveTransfers(2);
                ch = 2'(randBits(2));
                cpuWrite(`DMA_OFF_SINGLEMASK, {6'd0, ch});
                dreq = 4'hF;
                serveTransfers(2);
                cpuWrite(`DMA_OFF_ALLMASK, 8'(randBits(4)));
                dreq = 4'hF;
                serveTransfers(3);

                // Software request on a masked channel runs to terminal count
                ch = 2'(randBits(2));
                count = randBits(2);
                modeBits = 4'(randBits(4)) & 4'b1011;
                programChannel(ch, randBits(16), count);
                cpuWrite(`DMA_OFF_MODE, {2'b00, modeBits, ch});
                cpuWrite(`DMA_OFF_ALLMASK, 8'h0F);
                cpuWrite(`DMA_OFF_REQUEST, {5'd0, 1'b1, ch});
                serveTransfers(6);
                cpuRead(`DMA_OFF_STATUS);

                // Master clear with the byte pointer left on the high byte
                cpuRead(4'd0);
                cpuWrite(`DMA_OFF_MASTERCLEAR, 8'h00);
                cpuWrite(4'd1, 8'(randBits(8)));
                for (int c = 0; c < `DMA_CHANNELS; c++)
                        readChannel(2'(c));
                dreq = 4'hF;
                serveTransfers(2);
                cpuWrite(`DMA_OFF_CLEARMASK, 8'h00);
                dreq = 4'(randBits(4)) | 4'b0001;
                serveTransfers(4);
                cpuRead(`DMA_OFF_STATUS);

                $display("All tests passed!");
                $finish;
        end

endmodule

//--- dmaTimingControl.sv
`timescale 1ns/1ns
`include "dma_params.svh"

module dmaTimingControl import dmaPkg::*;
(
        input logic dma_if,
        input logic rstN,
        input dmaGrant_t grant,
        input logic hlda,
        input dmaMode_t chanMode,
        input logic [`DMA_ADDR_W-1:0] chanAddr,
        input logic terminalCount,
        output logic hrq,
        output dmaBusCycle_t bus,
        output logic advance,
        output logic [1:0] advanceChan
);

        dmaTimingState_t state;
        dmaTimingState_t nextState;
        logic [1:0] chan;

        always_ff @(posedge dma_if)
        begin
                if (!rstN)
                        state <= idle;
                else
                        state <= nextState;
        end

        // Channel held for the whole transfer
        always_ff @(posedge dma_if)
        begin
                if (state == idle && grant.valid)
                        chan <= grant.chan;
        end

        always_comb
        begin
                nextState = state;
                case (state)
                idle: if (grant.valid) nextState = request;
                // Wait here until the CPU gives up the bus
                request: if (hlda) nextState = address;
                address: nextState = strobe;
                strobe: nextState = idle;
                default: nextState = idle;
                endcase
        end

        assign hrq = (state != idle);
        assign advance = (state == strobe);
        assign advanceChan = chan;

        always_comb
        begin
                bus = '0;
                if (state == address || state == strobe)
                begin
                        bus.addr = chanAddr;
                        bus.dack = `DMA_CHANNELS'(1) << chan;
                end
                if (state == strobe)
                begin
                        case (chanMode.xferType)
                        toMemory:
                        begin
                                bus.ioRead = 1'b1;
                                bus.memWrite = 1'b1;
                        end
                        fromMemory:
                        begin
                                bus.memRead = 1'b1;
                                bus.ioWrite = 1'b1;
                        end
                        // Verify and the spare code drive no strobes
                        default: ;
                        endcase
                        bus.eop = terminalCount;
                end
        end

endmodule

//--- dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Channel count and register width of the 8237 register map
`define DMA_CHANNELS 4
`define DMA_ADDR_W 16

// Offsets 0 to 7 hold channel address (even) and count (odd)
// Status on read, command on write
`define DMA_OFF_STATUS 4'd8
`define DMA_OFF_REQUEST 4'd9
`define DMA_OFF_SINGLEMASK 4'd10
`define DMA_OFF_MODE 4'd11
`define DMA_OFF_CLEARFF 4'd12
// Reads as zero, no temporary register
`define DMA_OFF_MASTERCLEAR 4'd13
`define DMA_OFF_CLEARMASK 4'd14
`define DMA_OFF_ALLMASK 4'd15

`endif

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module dmaTb -f all.f -o dmaSim
./obj_dir/dmaSim | tee sim.log

if grep -q "All tests passed!" sim.log; then
        echo "Simulation PASSED"
else
        echo "Simulation FAILED"
        exit 1
fi
